// ==== hdl/gcu_pkg.sv ====
package gcu_pkg;

    // active CPU command, one op line held at a time
    typedef enum logic [2:0] {
        OP_IDLE,
        OP_SELECT_REG,
        OP_WRITE_REG,
        OP_SET_PTR,
        OP_WRITE_RAM,
        OP_READ_RAM_H,
        OP_READ_RAM_L
    } gcu_op_e;

    // bus and RAM widths
    localparam int DATA_W    = 16;
    localparam int VRAM_AW   = 13;
    localparam int LAYER_AW  = 11;
    localparam int SPRITE_AW = 10;

    // register select keeps bit 7 and the low nibble
    localparam logic [7:0] REG_SEL_MASK = 8'h8F;
    localparam int SCROLL_REGS = 8;

    // video RAM region map
    localparam logic [VRAM_AW-1:0] SCR0_BASE   = 13'h0000;
    localparam logic [VRAM_AW-1:0] SCR1_BASE   = 13'h0800;
    localparam logic [VRAM_AW-1:0] SCR2_BASE   = 13'h1000;
    localparam logic [VRAM_AW-1:0] SPRITE_BASE = 13'h1800;
    localparam logic [VRAM_AW-1:0] VRAM_TOP    = 13'h1C00;

    // vertical interrupt
    localparam logic [8:0] VINT_LINE = 9'h0E6;
    localparam logic [2:0][7:0] VINT_ACK_REGS = {8'h8F, 8'h0F, 8'h0E};

endpackage

// ==== hdl/gcu_vram_if.sv ====
`timescale 1ns/1ps

interface gcu_vram_if;

    logic [gcu_pkg::VRAM_AW-1:0] addr;
    logic [gcu_pkg::DATA_W-1:0]  wdata;
    logic                        we;
    // one cycle after addr
    logic [gcu_pkg::DATA_W-1:0]  rdata;

    modport cpu (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport ram (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

// ==== hdl/gcu_cpu_port.sv ====
`timescale 1ns/1ps

module gcu_cpu_port (
    input  logic                       CLK96,
    input  logic                       RESET96,
    input  logic [gcu_pkg::DATA_W-1:0] din,
    input  logic                       op_select_reg,
    input  logic                       op_write_reg,
    input  logic                       op_write_ram,
    input  logic                       op_read_ram_h,
    input  logic                       op_read_ram_l,
    input  logic                       op_set_ram_ptr,
    output logic                       ack,
    output logic [gcu_pkg::DATA_W-1:0] dout,
    output logic                       reg_select,
    output logic                       reg_write,
    gcu_vram_if.cpu                    vram
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WR_INC,
        ST_RD_WAIT,
        ST_RD_LOAD
    } seq_state_e;

    gcu_pkg::gcu_op_e op_cur;
    gcu_pkg::gcu_op_e op_last;
    seq_state_e       state;
    logic             op_start;
    logic             is_read;

    logic [gcu_pkg::DATA_W-1:0]  ptr;
    logic [gcu_pkg::VRAM_AW-1:0] rd_offset;
    logic [gcu_pkg::VRAM_AW-1:0] ram_addr;
    logic [gcu_pkg::DATA_W-1:0]  ram_wdata;
    logic                        ram_we;

    // op lines to one command
    always_comb begin
        if (op_select_reg)
            op_cur = gcu_pkg::OP_SELECT_REG;
        else if (op_write_reg)
            op_cur = gcu_pkg::OP_WRITE_REG;
        else if (op_set_ram_ptr)
            op_cur = gcu_pkg::OP_SET_PTR;
        else if (op_write_ram)
            op_cur = gcu_pkg::OP_WRITE_RAM;
        else if (op_read_ram_h)
            op_cur = gcu_pkg::OP_READ_RAM_H;
        else if (op_read_ram_l)
            op_cur = gcu_pkg::OP_READ_RAM_L;
        else
            op_cur = gcu_pkg::OP_IDLE;
    end

    // a held op acts only once
    assign op_start = (op_cur != op_last);
    assign is_read  = (op_cur == gcu_pkg::OP_READ_RAM_H) || (op_cur == gcu_pkg::OP_READ_RAM_L);
    assign rd_offset = {{(gcu_pkg::VRAM_AW-1){1'b0}}, op_cur == gcu_pkg::OP_READ_RAM_L};

    assign reg_select = op_start && (op_cur == gcu_pkg::OP_SELECT_REG);
    assign reg_write  = op_start && (op_cur == gcu_pkg::OP_WRITE_REG);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            op_last <= gcu_pkg::OP_IDLE;
            state   <= ST_IDLE;
            ack     <= 1'b1;
            ram_we  <= 1'b0;
            ptr     <= '0;
        end else begin
            op_last <= op_cur;
            ram_we  <= 1'b0;
            if (op_start) begin
                state <= ST_IDLE;
                ack   <= 1'b1;
                case (op_cur)
                    gcu_pkg::OP_SET_PTR: ptr <= din;
                    gcu_pkg::OP_WRITE_RAM: begin
                        ram_we <= 1'b1;
                        ack    <= 1'b0;
                        state  <= ST_WR_INC;
                    end
                    gcu_pkg::OP_READ_RAM_H, gcu_pkg::OP_READ_RAM_L: begin
                        ack   <= 1'b0;
                        state <= ST_RD_WAIT;
                    end
                    default: ;
                endcase
            end else begin
                case (state)
                    ST_WR_INC: begin
                        ptr   <= ptr + 1'b1;
                        ack   <= 1'b1;
                        state <= ST_IDLE;
                    end
                    // RAM output settles here
                    ST_RD_WAIT: state <= ST_RD_LOAD;
                    ST_RD_LOAD: begin
                        ack   <= 1'b1;
                        state <= ST_IDLE;
                    end
                    default: ;
                endcase
            end
        end
    end

    // address, write data and read result
    always_ff @(posedge CLK96) begin
        if (op_start && op_cur == gcu_pkg::OP_WRITE_RAM) begin
            ram_addr  <= ptr[gcu_pkg::VRAM_AW-1:0];
            ram_wdata <= din;
        end else if (op_start && is_read) begin
            ram_addr <= ptr[gcu_pkg::VRAM_AW-1:0] + rd_offset;
        end
        if (!op_start && state == ST_RD_LOAD)
            dout <= vram.rdata;
    end

    assign vram.addr  = ram_addr;
    assign vram.wdata = ram_wdata;
    assign vram.we    = ram_we;

endmodule

// ==== hdl/gcu_scroll_regs.sv ====
`timescale 1ns/1ps

module gcu_scroll_regs (
    input  logic                       CLK96,
    input  logic                       RESET96,
    input  logic [gcu_pkg::DATA_W-1:0] din,
    input  logic                       reg_select,
    input  logic                       reg_write,
    output logic [gcu_pkg::DATA_W-1:0] bg_scroll_x,
    output logic [gcu_pkg::DATA_W-1:0] bg_scroll_y,
    output logic [gcu_pkg::DATA_W-1:0] fg_scroll_x,
    output logic [gcu_pkg::DATA_W-1:0] fg_scroll_y,
    output logic [gcu_pkg::DATA_W-1:0] text_scroll_x,
    output logic [gcu_pkg::DATA_W-1:0] text_scroll_y,
    output logic [gcu_pkg::DATA_W-1:0] sprite_scroll_x,
    output logic [gcu_pkg::DATA_W-1:0] sprite_scroll_y,
    output logic                       vint_ack
);

    logic [7:0]                 reg_num;
    logic [gcu_pkg::DATA_W-1:0] scroll [gcu_pkg::SCROLL_REGS];

    // 0xFF after reset, so nothing is selected
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            reg_num <= 8'hFF;
        end else if (reg_select) begin
            reg_num <= din[7:0] & gcu_pkg::REG_SEL_MASK;
        end
    end

    // entries 0..7 and 0x80..0x87 only, bit 3 marks the others
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            for (int i = 0; i < gcu_pkg::SCROLL_REGS; i++) begin
                scroll[i] <= '0;
            end
        end else if (reg_write && !reg_num[3]) begin
            scroll[reg_num[2:0]] <= din;
        end
    end

    always_comb begin
        vint_ack = 1'b0;
        for (int i = 0; i < $size(gcu_pkg::VINT_ACK_REGS); i++) begin
            if (reg_num == gcu_pkg::VINT_ACK_REGS[i])
                vint_ack = 1'b1;
        end
    end

    assign bg_scroll_x     = scroll[0];
    assign bg_scroll_y     = scroll[1];
    assign fg_scroll_x     = scroll[2];
    assign fg_scroll_y     = scroll[3];
    assign text_scroll_x   = scroll[4];
    assign text_scroll_y   = scroll[5];
    assign sprite_scroll_x = scroll[6];
    assign sprite_scroll_y = scroll[7];

endmodule

// ==== hdl/gcu_vram.sv ====
`timescale 1ns/1ps

module gcu_vram (
    input  logic                          CLK96,
    input  logic [gcu_pkg::LAYER_AW-1:0]  scr0_addr,
    input  logic [gcu_pkg::LAYER_AW-1:0]  scr1_addr,
    input  logic [gcu_pkg::LAYER_AW-1:0]  scr2_addr,
    input  logic [gcu_pkg::SPRITE_AW-1:0] sprite_addr,
    output logic [gcu_pkg::DATA_W-1:0]    scr0_data,
    output logic [gcu_pkg::DATA_W-1:0]    scr1_data,
    output logic [gcu_pkg::DATA_W-1:0]    scr2_data,
    output logic [gcu_pkg::DATA_W-1:0]    sprite_data,
    gcu_vram_if.ram                       vram
);

    logic [gcu_pkg::DATA_W-1:0] main_mem   [2**gcu_pkg::VRAM_AW];
    logic [gcu_pkg::DATA_W-1:0] sprite_mem [2**gcu_pkg::SPRITE_AW];

    // index 0..2 are the scroll layers, 3 is sprites
    logic [3:0][gcu_pkg::VRAM_AW-1:0]  region_lo;
    logic [3:0][gcu_pkg::VRAM_AW-1:0]  region_hi;
    logic [3:0][gcu_pkg::VRAM_AW-1:0]  region_off;
    logic [3:0]                        region_we;
    logic [2:0][gcu_pkg::LAYER_AW-1:0] layer_raddr;
    logic [2:0][gcu_pkg::DATA_W-1:0]   layer_q;

    assign region_lo = {gcu_pkg::SPRITE_BASE, gcu_pkg::SCR2_BASE,
                        gcu_pkg::SCR1_BASE, gcu_pkg::SCR0_BASE};
    assign region_hi = {gcu_pkg::VRAM_TOP, gcu_pkg::SPRITE_BASE,
                        gcu_pkg::SCR2_BASE, gcu_pkg::SCR1_BASE};

    for (genvar r = 0; r < 4; r++) begin : g_region
        assign region_we[r]  = vram.we && (vram.addr >= region_lo[r]) && (vram.addr < region_hi[r]);
        assign region_off[r] = vram.addr - region_lo[r];
    end

    // main RAM seen by the CPU port
    always_ff @(posedge CLK96) begin
        if (vram.we)
            main_mem[vram.addr] <= vram.wdata;
        vram.rdata <= main_mem[vram.addr];
    end

    assign layer_raddr = {scr2_addr, scr1_addr, scr0_addr};

    // scroll layer mirrors
    for (genvar l = 0; l < 3; l++) begin : g_layer
        logic [gcu_pkg::DATA_W-1:0] mem [2**gcu_pkg::LAYER_AW];

        always_ff @(posedge CLK96) begin
            if (region_we[l])
                mem[region_off[l][gcu_pkg::LAYER_AW-1:0]] <= vram.wdata;
            layer_q[l] <= mem[layer_raddr[l]];
        end
    end

    // sprite mirror
    always_ff @(posedge CLK96) begin
        if (region_we[3])
            sprite_mem[region_off[3][gcu_pkg::SPRITE_AW-1:0]] <= vram.wdata;
        sprite_data <= sprite_mem[sprite_addr];
    end

    assign scr0_data = layer_q[0];
    assign scr1_data = layer_q[1];
    assign scr2_data = layer_q[2];

endmodule

// ==== hdl/gcu_video_timing.sv ====
`timescale 1ns/1ps

module gcu_video_timing (
    input  logic       CLK96,
    input  logic       RESET96,
    input  logic [8:0] h,
    input  logic [8:0] v,
    input  logic [8:0] hs_start,
    input  logic [8:0] hs_end,
    input  logic [8:0] vs_start,
    input  logic [8:0] vs_end,
    input  logic       vint_ack,
    output logic       hsync,
    output logic       vsync,
    output logic       fblank,
    output logic       vint
);

    logic in_hs;
    logic in_vs;

    // horizontal bounds exclusive, vertical inclusive
    assign in_hs = (h > hs_start) && (h < hs_end);
    assign in_vs = (v >= vs_start) && (v <= vs_end);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            fblank <= 1'b1;
            vint   <= 1'b0;
        end else begin
            hsync  <= !in_hs;
            vsync  <= !in_vs;
            fblank <= !(in_hs || in_vs);
            // line drops on the interrupt scanline or on acknowledge
            vint   <= !((v == gcu_pkg::VINT_LINE) || vint_ack);
        end
    end

endmodule

// ==== hdl/gcu_top.sv ====
`timescale 1ns/1ps

module gcu_top (
    input  logic        CLK96,
    input  logic        RESET96,
    input  logic [15:0] din,
    input  logic        op_select_reg,
    input  logic        op_write_reg,
    input  logic        op_write_ram,
    input  logic        op_read_ram_h,
    input  logic        op_read_ram_l,
    input  logic        op_set_ram_ptr,
    input  logic [8:0]  h,
    input  logic [8:0]  v,
    input  logic [8:0]  hs_start,
    input  logic [8:0]  hs_end,
    input  logic [8:0]  vs_start,
    input  logic [8:0]  vs_end,
    input  logic [10:0] scr0_addr,
    input  logic [10:0] scr1_addr,
    input  logic [10:0] scr2_addr,
    input  logic [9:0]  sprite_addr,
    output logic        ack,
    output logic [15:0] dout,
    output logic        vint,
    output logic        hsync,
    output logic        vsync,
    output logic        fblank,
    output logic [15:0] bg_scroll_x,
    output logic [15:0] bg_scroll_y,
    output logic [15:0] fg_scroll_x,
    output logic [15:0] fg_scroll_y,
    output logic [15:0] text_scroll_x,
    output logic [15:0] text_scroll_y,
    output logic [15:0] sprite_scroll_x,
    output logic [15:0] sprite_scroll_y,
    output logic [15:0] scr0_data,
    output logic [15:0] scr1_data,
    output logic [15:0] scr2_data,
    output logic [15:0] sprite_data
);

    logic reg_select;
    logic reg_write;
    logic vint_ack;

    gcu_vram_if vram_bus ();

    gcu_cpu_port gcu_cpu_port_inst (
        .CLK96          (CLK96),
        .RESET96        (RESET96),
        .din            (din),
        .op_select_reg  (op_select_reg),
        .op_write_reg   (op_write_reg),
        .op_write_ram   (op_write_ram),
        .op_read_ram_h  (op_read_ram_h),
        .op_read_ram_l  (op_read_ram_l),
        .op_set_ram_ptr (op_set_ram_ptr),
        .ack            (ack),
        .dout           (dout),
        .reg_select     (reg_select),
        .reg_write      (reg_write),
        .vram           (vram_bus.cpu)
    );

    gcu_scroll_regs gcu_scroll_regs_inst (
        .CLK96           (CLK96),
        .RESET96         (RESET96),
        .din             (din),
        .reg_select      (reg_select),
        .reg_write       (reg_write),
        .bg_scroll_x     (bg_scroll_x),
        .bg_scroll_y     (bg_scroll_y),
        .fg_scroll_x     (fg_scroll_x),
        .fg_scroll_y     (fg_scroll_y),
        .text_scroll_x   (text_scroll_x),
        .text_scroll_y   (text_scroll_y),
        .sprite_scroll_x (sprite_scroll_x),
        .sprite_scroll_y (sprite_scroll_y),
        .vint_ack        (vint_ack)
    );

    gcu_vram gcu_vram_inst (
        .CLK96       (CLK96),
        .scr0_addr   (scr0_addr),
        .scr1_addr   (scr1_addr),
        .scr2_addr   (scr2_addr),
        .sprite_addr (sprite_addr),
        .scr0_data   (scr0_data),
        .scr1_data   (scr1_data),
        .scr2_data   (scr2_data),
        .sprite_data (sprite_data),
        .vram        (vram_bus.ram)
    );

    gcu_video_timing gcu_video_timing_inst (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .h        (h),
        .v        (v),
        .hs_start (hs_start),
        .hs_end   (hs_end),
        .vs_start (vs_start),
        .vs_end   (vs_end),
        .vint_ack (vint_ack),
        .hsync    (hsync),
        .vsync    (vsync),
        .fblank   (fblank),
        .vint     (vint)
    );

endmodule

// ==== verif/gcu_properties.sv ====
`timescale 1ns/1ps

module gcu_properties (
    input logic                       CLK96,
    input logic                       RESET96,
    input logic                       ack,
    input logic                       ram_we,
    input logic [gcu_pkg::DATA_W-1:0] ptr,
    input gcu_pkg::gcu_op_e           op_cur
);

    int assert_failures = 0;

    // reads hold ack low for two cycles, writes for one
    ack_low_max_two: assert property (
        @(posedge CLK96) disable iff (RESET96) !ack [*2] |=> ack
    ) else begin
        assert_failures++;
        $error("ack low for more than two cycles");
    end

    // a write is one we pulse, then the pointer steps by one
    write_single_pulse: assert property (
        @(posedge CLK96) disable iff (RESET96)
            ram_we |=> !ram_we && (ptr == $past(ptr) + 1'b1)
    ) else begin
        assert_failures++;
        $error("vram we not a single pulse followed by a pointer increment");
    end

    ack_when_idle: assert property (
        @(posedge CLK96) disable iff (RESET96) (op_cur == gcu_pkg::OP_IDLE) |-> ack
    ) else begin
        assert_failures++;
        $error("ack low while no op is active");
    end

endmodule

bind gcu_cpu_port gcu_properties gcu_properties_inst (
    .CLK96   (CLK96),
    .RESET96 (RESET96),
    .ack     (ack),
    .ram_we  (ram_we),
    .ptr     (ptr),
    .op_cur  (op_cur)
);

// ==== verif/gcu_tb.sv ====
`timescale 1ns/1ps

module gcu_tb;

    localparam int REG_OPS       = 48;
    localparam int BURST_LEN     = 16;
    localparam int MIRROR_WRITES = 8;
    localparam int SYNC_SAMPLES  = 40;
    localparam int INT_SAMPLES   = 24;
    // each op or sample gets up to 8 cycles of 10 ns
    localparam int TOTAL_OPS = 2 * REG_OPS + 4 * BURST_LEN + 5 * (MIRROR_WRITES + 1)
                               + SYNC_SAMPLES + 2 * INT_SAMPLES;
    localparam int TIMEOUT_NS = 2 * TOTAL_OPS * 8 * 10 + 2000;

    logic        CLK96;
    logic        RESET96;
    logic [15:0] din;
    logic        op_select_reg;
    logic        op_write_reg;
    logic        op_write_ram;
    logic        op_read_ram_h;
    logic        op_read_ram_l;
    logic        op_set_ram_ptr;
    logic [8:0]  h;
    logic [8:0]  v;
    logic [8:0]  hs_start;
    logic [8:0]  hs_end;
    logic [8:0]  vs_start;
    logic [8:0]  vs_end;
    logic [10:0] scr0_addr;
    logic [10:0] scr1_addr;
    logic [10:0] scr2_addr;
    logic [9:0]  sprite_addr;
    logic        ack;
    logic [15:0] dout;
    logic        vint;
    logic        hsync;
    logic        vsync;
    logic        fblank;
    logic [15:0] scr0_data;
    logic [15:0] scr1_data;
    logic [15:0] scr2_data;
    logic [15:0] sprite_data;
    wire  [7:0][15:0] scroll_out;

    // reference model
    logic [15:0] vram_model [8192];
    logic [15:0] scroll_model [8];
    logic [15:0] ptr_model;
    logic [7:0]  sel_model;

    int errors;
    int checks;
    int test_errors;
    int tests_run;
    int tests_failed;
    int assert_errors;

    gcu_top gcu_top_inst (
        .CLK96           (CLK96),
        .RESET96         (RESET96),
        .din             (din),
        .op_select_reg   (op_select_reg),
        .op_write_reg    (op_write_reg),
        .op_write_ram    (op_write_ram),
        .op_read_ram_h   (op_read_ram_h),
        .op_read_ram_l   (op_read_ram_l),
        .op_set_ram_ptr  (op_set_ram_ptr),
        .h               (h),
        .v               (v),
        .hs_start        (hs_start),
        .hs_end          (hs_end),
        .vs_start        (vs_start),
        .vs_end          (vs_end),
        .scr0_addr       (scr0_addr),
        .scr1_addr       (scr1_addr),
        .scr2_addr       (scr2_addr),
        .sprite_addr     (sprite_addr),
        .ack             (ack),
        .dout            (dout),
        .vint            (vint),
        .hsync           (hsync),
        .vsync           (vsync),
        .fblank          (fblank),
        .bg_scroll_x     (scroll_out[0]),
        .bg_scroll_y     (scroll_out[1]),
        .fg_scroll_x     (scroll_out[2]),
        .fg_scroll_y     (scroll_out[3]),
        .text_scroll_x   (scroll_out[4]),
        .text_scroll_y   (scroll_out[5]),
        .sprite_scroll_x (scroll_out[6]),
        .sprite_scroll_y (scroll_out[7]),
        .scr0_data       (scr0_data),
        .scr1_data       (scr1_data),
        .scr2_data       (scr2_data),
        .sprite_data     (sprite_data)
    );

    always #5 CLK96 = ~CLK96;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED %s: expected %0h, actual %0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic release_ops();
        op_select_reg  <= 1'b0;
        op_write_reg   <= 1'b0;
        op_write_ram   <= 1'b0;
        op_read_ram_h  <= 1'b0;
        op_read_ram_l  <= 1'b0;
        op_set_ram_ptr <= 1'b0;
    endtask

    // one op line held until the op completes, then all lines low
    task automatic run_op(input gcu_pkg::gcu_op_e op, input logic [15:0] data);
        int waited;
        waited = 0;
        @(posedge CLK96);
        din <= data;
        case (op)
            gcu_pkg::OP_SELECT_REG: op_select_reg  <= 1'b1;
            gcu_pkg::OP_WRITE_REG:  op_write_reg   <= 1'b1;
            gcu_pkg::OP_SET_PTR:    op_set_ram_ptr <= 1'b1;
            gcu_pkg::OP_WRITE_RAM:  op_write_ram   <= 1'b1;
            gcu_pkg::OP_READ_RAM_H: op_read_ram_h  <= 1'b1;
            gcu_pkg::OP_READ_RAM_L: op_read_ram_l  <= 1'b1;
            default: ;
        endcase
        @(posedge CLK96);
        if (op inside {gcu_pkg::OP_WRITE_RAM, gcu_pkg::OP_READ_RAM_H,
                       gcu_pkg::OP_READ_RAM_L}) begin
            do begin
                @(negedge CLK96);
                waited++;
            end while (!ack && waited < 8);
            if (!ack) begin
                errors++;
                test_errors++;
                $display("ack did not return high after a %s op", op.name());
            end
            @(posedge CLK96);
        end
        release_ops();
    endtask

    task automatic select_reg(input logic [15:0] value);
        run_op(gcu_pkg::OP_SELECT_REG, value);
        sel_model = value[7:0] & 8'h8F;
    endtask

    task automatic write_reg(input logic [15:0] value);
        run_op(gcu_pkg::OP_WRITE_REG, value);
        if (sel_model[6:0] < 7'd8)
            scroll_model[sel_model[2:0]] = value;
    endtask

    task automatic set_ptr(input logic [15:0] value);
        run_op(gcu_pkg::OP_SET_PTR, value);
        ptr_model = value;
    endtask

    task automatic write_ram(input logic [15:0] value);
        run_op(gcu_pkg::OP_WRITE_RAM, value);
        vram_model[ptr_model[12:0]] = value;
        ptr_model = ptr_model + 16'd1;
    endtask

    task automatic read_ram(input logic low_word, input string name);
        logic [12:0] addr;
        addr = ptr_model[12:0] + (low_word ? 13'd1 : 13'd0);
        run_op(low_word ? gcu_pkg::OP_READ_RAM_L : gcu_pkg::OP_READ_RAM_H, 16'($urandom));
        @(negedge CLK96);
        check(name, vram_model[addr], dout);
    endtask

    task automatic test_reset();
        @(negedge CLK96);
        for (int i = 0; i < 8; i++)
            check("reset scroll", 32'd0, scroll_out[i]);
        check("reset ack", 32'd1, ack);
        check("reset vint", 32'd0, vint);
        check("reset hsync", 32'd1, hsync);
        check("reset vsync", 32'd1, vsync);
        check("reset fblank", 32'd1, fblank);
        finish_test("reset");
    endtask

    task automatic test_scroll_regs();
        for (int i = 0; i < REG_OPS; i++) begin
            select_reg(16'($urandom));
            write_reg(16'($urandom));
            @(negedge CLK96);
            for (int r = 0; r < 8; r++)
                check("scroll regs", scroll_model[r], scroll_out[r]);
        end
        finish_test("scroll regs");
    endtask

    task automatic test_ram();
        logic [15:0] start;
        start = 16'($urandom);
        set_ptr(start);
        repeat (BURST_LEN) write_ram(16'($urandom));
        // last L read would fall past the burst
        for (int i = 0; i < BURST_LEN; i++) begin
            set_ptr(start + 16'(i));
            read_ram(1'b0, "ram read h");
            if (i < BURST_LEN - 1)
                read_ram(1'b1, "ram read l");
        end
        finish_test("ram write read");
    endtask

    task automatic test_mirrors();
        int base_a [4];
        int size_a [4];
        int off_a [4];
        base_a = '{32'h0000, 32'h0800, 32'h1000, 32'h1800};
        size_a = '{2048, 2048, 2048, 1024};
        for (int r = 0; r < 4; r++) begin
            off_a[r] = $urandom % (size_a[r] - MIRROR_WRITES);
            set_ptr(16'(base_a[r] + off_a[r]));
            repeat (MIRROR_WRITES) write_ram(16'($urandom));
        end
        for (int k = 0; k < MIRROR_WRITES; k++) begin
            @(posedge CLK96);
            scr0_addr   <= 11'(off_a[0] + k);
            scr1_addr   <= 11'(off_a[1] + k);
            scr2_addr   <= 11'(off_a[2] + k);
            sprite_addr <= 10'(off_a[3] + k);
            @(posedge CLK96);
            @(negedge CLK96);
            check("scr0 mirror", vram_model[base_a[0] + off_a[0] + k], scr0_data);
            check("scr1 mirror", vram_model[base_a[1] + off_a[1] + k], scr1_data);
            check("scr2 mirror", vram_model[base_a[2] + off_a[2] + k], scr2_data);
            check("sprite mirror", vram_model[base_a[3] + off_a[3] + k], sprite_data);
        end
        finish_test("layer mirrors");
    endtask

    task automatic test_sync();
        logic [8:0] hv;
        logic [8:0] vv;
        logic [8:0] hs0;
        logic [8:0] hs1;
        logic [8:0] vs0;
        logic [8:0] vs1;
        logic       exp_hs;
        logic       exp_vs;
        for (int i = 0; i < SYNC_SAMPLES; i++) begin
            // windows near the counters so both sides get hit
            hs0 = 9'($urandom % 400);
            hs1 = hs0 + 9'($urandom % 100);
            hv  = hs0 - 9'd10 + 9'($urandom % 120);
            vs0 = 9'($urandom % 400);
            vs1 = vs0 + 9'($urandom % 60);
            vv  = vs0 - 9'd10 + 9'($urandom % 80);
            @(posedge CLK96);
            h        <= hv;
            v        <= vv;
            hs_start <= hs0;
            hs_end   <= hs1;
            vs_start <= vs0;
            vs_end   <= vs1;
            @(posedge CLK96);
            @(negedge CLK96);
            exp_hs = !((hv > hs0) && (hv < hs1));
            exp_vs = !((vv >= vs0) && (vv <= vs1));
            check("hsync", exp_hs, hsync);
            check("vsync", exp_vs, vsync);
            check("fblank", exp_hs && exp_vs, fblank);
        end
        finish_test("sync blank");
    endtask

    task automatic test_vint();
        logic [15:0] sel_val;
        logic [8:0]  vv;
        logic        exp_vint;
        for (int i = 0; i < INT_SAMPLES; i++) begin
            case ($urandom % 6)
                0: sel_val = 16'h000E;
                1: sel_val = 16'h000F;
                2: sel_val = 16'h008F;
                3: sel_val = 16'h0086;
                default: sel_val = 16'($urandom);
            endcase
            if ($urandom % 2)
                select_reg(sel_val);
            vv = ($urandom % 3 == 0) ? 9'd230 : 9'($urandom);
            @(posedge CLK96);
            v <= vv;
            @(posedge CLK96);
            @(negedge CLK96);
            exp_vint = !((vv == 9'd230) || (sel_model == 8'h0E) ||
                         (sel_model == 8'h0F) || (sel_model == 8'h8F));
            check("vint", exp_vint, vint);
        end
        finish_test("interrupt");
    endtask

    initial begin
        CLK96       = 1'b0;
        RESET96     = 1'b1;
        din         = '0;
        h           = '0;
        v           = '0;
        hs_start    = '0;
        hs_end      = '0;
        vs_start    = '0;
        vs_end      = '0;
        scr0_addr   = '0;
        scr1_addr   = '0;
        scr2_addr   = '0;
        sprite_addr = '0;
        release_ops();
        errors       = 0;
        checks       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        ptr_model    = '0;
        sel_model    = 8'hFF;
        for (int i = 0; i < 8; i++)
            scroll_model[i] = '0;
        void'($urandom(59));

        repeat (2) @(posedge CLK96);
        RESET96 <= 1'b0;

        test_reset();
        test_scroll_regs();
        test_ram();
        test_mirrors();
        test_sync();
        test_vint();

        assert_errors = gcu_top_inst.gcu_cpu_port_inst.gcu_properties_inst.assert_failures;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, checks, errors, assert_errors);
        if (errors == 0 && tests_failed == 0 && assert_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run timed out after %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== files.f ====
hdl/gcu_pkg.sv
hdl/gcu_vram_if.sv
hdl/gcu_cpu_port.sv
hdl/gcu_scroll_regs.sv
hdl/gcu_vram.sv
hdl/gcu_video_timing.sv
hdl/gcu_top.sv
verif/gcu_properties.sv
verif/gcu_tb.sv
